//--- dbg_terminal.f
hw/dbg_pkg.sv
hw/bin2bcd.sv
hw/cmd_decoder.sv
hw/status_line.sv
hw/report_seq.sv
hw/dbg_terminal.sv
tests/dbg_terminal_tb.sv

//--- tests/dbg_terminal_tb.sv
/*
  Testbench for the debug terminal
  Stimulus table of command bytes, timestamps and tx_busy modes
  Flag model, expected status line and tx monitor
*/

`timescale 1ns/10ps

module dbg_terminal_tb;

  typedef enum logic [1:0] {
    BUSY_NONE,
    BUSY_ALT,
    BUSY_RAND
  } busy_mode_t;

  // One table entry, commands sent from the highest used byte down
  typedef struct packed {
    logic [1:0]                  n_cmds;
    logic [2:0][7:0]             cmds;
    logic                        ts_rand;
    logic [dbg_pkg::TS_BITS-1:0] ts;
    busy_mode_t                  busy;
    logic                        retrig;
  } step_t;

  localparam int N_STEPS      = 8;
  localparam int LINE_TIMEOUT = 400;
  localparam int IDLE_CYCLES  = 30;

  // DUT ports
  logic                        clk;
  logic                        rst;
  logic                        tmr;
  logic [dbg_pkg::TS_BITS-1:0] timestamp;
  logic [7:0]                  rx_data;
  logic                        new_rx_data;
  logic                        tx_busy;
  logic [7:0]                  tx_data;
  logic                        new_tx_data;
  dbg_pkg::dbg_status_t        status;
  logic                        reset_req;

  // Current back-pressure pattern
  busy_mode_t           busy_mode;
  // Characters seen on the link
  logic [7:0]           line_q [$];
  // Expected flags
  dbg_pkg::dbg_status_t exp_status;
  step_t                steps [N_STEPS];

  dbg_terminal i_dbg_terminal (
    .clk         (clk),
    .rst         (rst),
    .tmr         (tmr),
    .timestamp   (timestamp),
    .rx_data     (rx_data),
    .new_rx_data (new_rx_data),
    .tx_busy     (tx_busy),
    .tx_data     (tx_data),
    .new_tx_data (new_tx_data),
    .status      (status),
    .reset_req   (reset_req)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Link back-pressure, updated just after each rising edge
  initial begin
    forever begin
      @(posedge clk);
      #1;
      case (busy_mode)
        BUSY_ALT:  tx_busy = ~tx_busy;
        BUSY_RAND: tx_busy = ($urandom % 2) == 1;
        default:   tx_busy = 1'b0;
      endcase
    end
  end

  // Fail message and stop
  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic report_mismatch(input string what);
    $display("error: t=%0t %s", $time, what);
    stop_run();
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    stop_run();
  endtask

  // tx monitor, sampled mid-cycle
  initial begin
    forever begin
      @(negedge clk);
      if (!rst && new_tx_data) begin
        if (tx_busy) begin
          report_mismatch("new_tx_data high while tx_busy is high");
        end
        line_q.push_back(tx_data);
      end
    end
  end

  task automatic check_char(input logic [7:0] exp, input logic [7:0] act, input int pos);
    if (act !== exp) begin
      report_mismatch($sformatf("char %0d is %h, expected %h", pos, act, exp));
    end
  endtask

  task automatic check_status(input dbg_pkg::dbg_status_t exp, input dbg_pkg::dbg_status_t act);
    if (act !== exp) begin
      report_mismatch($sformatf("status is %b, expected %b", act, exp));
    end
  endtask

  task automatic check_reset_req(input logic exp, input logic act);
    if (act !== exp) begin
      report_mismatch($sformatf("reset_req is %b, expected %b", act, exp));
    end
  endtask

  // ASCII code of decimal digit k of v, digit 0 least significant
  function automatic logic [7:0] digit_ascii(input logic [dbg_pkg::TS_BITS-1:0] v, input int k);
    int unsigned q;
    q = v;
    repeat (k) q = q / 10;
    return 8'(8'h30 + q % 10);
  endfunction

  // Expected character of the status line at position pos
  function automatic logic [7:0] line_char(input dbg_pkg::dbg_status_t st,
                                           input logic [dbg_pkg::TS_BITS-1:0] ts,
                                           input int pos);
    case (pos)
      1:       return st.motor_armed ? "A" : "D";
      3:       return st.logging ? "R" : "I";
      5:       return "T";
      6:       return ":";
      8:       return digit_ascii(ts, 5);
      9:       return digit_ascii(ts, 4);
      10:      return digit_ascii(ts, 3);
      11:      return ".";
      12:      return digit_ascii(ts, 2);
      15:      return 8'h0d;
      default: return " ";
    endcase
  endfunction

  function automatic step_t make_step(input logic [1:0] n, input logic [23:0] cmds,
                                      input logic ts_rand, input logic [23:0] ts,
                                      input busy_mode_t busy, input logic retrig);
    step_t s;
    s.n_cmds  = n;
    s.cmds    = cmds;
    s.ts_rand = ts_rand;
    s.ts      = ts;
    s.busy    = busy;
    s.retrig  = retrig;
    return s;
  endfunction

  // One strobed byte, then the flag and request checks
  task automatic send_cmd(input logic [7:0] b);
    @(posedge clk);
    #1;
    rx_data     = b;
    new_rx_data = 1'b1;
    // No request before the byte is taken
    @(negedge clk);
    check_reset_req(1'b0, reset_req);
    @(posedge clk);
    #1;
    new_rx_data = 1'b0;
    rx_data     = 8'h00;
    if (b == dbg_pkg::CMD_MOTOR) begin
      exp_status.motor_armed = ~exp_status.motor_armed;
    end
    if (b == dbg_pkg::CMD_DATA) begin
      exp_status.logging = ~exp_status.logging;
    end
    // Cycle after the strobe
    @(negedge clk);
    check_status(exp_status, status);
    check_reset_req(b == dbg_pkg::CMD_RESET, reset_req);
    // Request gone one cycle later
    @(negedge clk);
    check_reset_req(1'b0, reset_req);
    check_status(exp_status, status);
  endtask

  // Trigger pulse, timestamp moves away right after capture
  task automatic send_trigger(input logic [dbg_pkg::TS_BITS-1:0] ts, input logic retrig);
    logic [31:0] rnd;
    rnd = $urandom;
    @(posedge clk);
    #1;
    timestamp = ts;
    tmr       = 1'b1;
    @(posedge clk);
    #1;
    tmr       = 1'b0;
    timestamp = ts ^ (rnd[dbg_pkg::TS_BITS-1:0] | 24'd1);
    // Second pulse lands in the middle of the line
    if (retrig) begin
      repeat (3) @(posedge clk);
      #1;
      tmr = 1'b1;
      @(posedge clk);
      #1;
      tmr = 1'b0;
    end
  endtask

  task automatic wait_line();
    int cycles;
    cycles = 0;
    while (line_q.size() < dbg_pkg::LINE_LEN) begin
      @(negedge clk);
      cycles++;
      if (cycles > LINE_TIMEOUT) begin
        abort_run("timeout while waiting for the 16 characters of a status line");
      end
    end
  endtask

  task automatic run_step(input int n, input step_t s);
    logic [31:0]                 rnd;
    logic [dbg_pkg::TS_BITS-1:0] ts_val;
    dbg_pkg::dbg_status_t        snap_status;
    busy_mode = s.busy;
    for (int k = int'(s.n_cmds) - 1; k >= 0; k--) begin
      send_cmd(s.cmds[k]);
    end
    if (line_q.size() != 0) begin
      abort_run("a character was sent without a report trigger");
    end
    if (s.ts_rand) begin
      rnd    = $urandom;
      ts_val = rnd[dbg_pkg::TS_BITS-1:0];
    end else begin
      ts_val = s.ts;
    end
    // Flags as they stand at the trigger
    snap_status = exp_status;
    send_trigger(ts_val, s.retrig);
    wait_line();
    // Idle period, nothing more may arrive
    repeat (IDLE_CYCLES) @(negedge clk);
    if (line_q.size() != dbg_pkg::LINE_LEN) begin
      abort_run($sformatf("step %0d sent %0d characters instead of 16", n, line_q.size()));
    end
    for (int i = 0; i < dbg_pkg::LINE_LEN; i++) begin
      check_char(line_char(snap_status, ts_val, i), line_q[i], i);
    end
    line_q.delete();
    $display("step %0d checked, timestamp %0d", n, ts_val);
  endtask

  initial begin
    void'($urandom(32'h9c01));
    rst         = 1'b1;
    tmr         = 1'b0;
    timestamp   = '0;
    rx_data     = 8'h00;
    new_rx_data = 1'b0;
    tx_busy     = 1'b0;
    busy_mode   = BUSY_NONE;
    exp_status  = '0;

    steps[0] = make_step(2'd0, 24'h0, 1'b0, 24'd0, BUSY_NONE, 1'b0);
    steps[1] = make_step(2'd1, "m", 1'b0, 24'd123456, BUSY_NONE, 1'b0);
    steps[2] = make_step(2'd2, "dx", 1'b0, 24'd16777215, BUSY_ALT, 1'b0);
    steps[3] = make_step(2'd1, "r", 1'b1, 24'd0, BUSY_RAND, 1'b0);
    steps[4] = make_step(2'd3, "mdq", 1'b1, 24'd0, BUSY_RAND, 1'b1);
    steps[5] = make_step(2'd1, "d", 1'b0, 24'd999999, BUSY_ALT, 1'b1);
    steps[6] = make_step(2'd3, "rmm", 1'b1, 24'd0, BUSY_NONE, 1'b1);
    steps[7] = make_step(2'd2, "dr", 1'b1, 24'd0, BUSY_RAND, 1'b0);

    // Reset for 4 cycles
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Clean state after reset
    @(negedge clk);
    check_status('0, status);
    check_reset_req(1'b0, reset_req);
    repeat (20) @(negedge clk);
    if (line_q.size() != 0) begin
      abort_run("characters appeared after reset without a trigger");
    end

    for (int n = 0; n < N_STEPS; n++) begin
      run_step(n, steps[n]);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- hw/dbg_terminal.sv
/*
  Debug terminal top level
  Command decoder, timestamp converter, report sequencer
  and line composer on a byte-serial link
*/

`timescale 1ns/10ps

module dbg_terminal (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        tmr,
  input  logic [dbg_pkg::TS_BITS-1:0] timestamp,
  input  logic [7:0]                  rx_data,
  input  logic                        new_rx_data,
  input  logic                        tx_busy,
  output logic [7:0]                  tx_data,
  output logic                        new_tx_data,
  output dbg_pkg::dbg_status_t        status,
  output logic                        reset_req
);

  // Live timestamp in decimal
  dbg_pkg::bcd_vec_t  ts_bcd;
  // Frozen line state and position
  dbg_pkg::dbg_snap_t snap;
  dbg_pkg::char_idx_t idx;

  // Terminal commands
  cmd_decoder i_cmd_decoder (
    .clk         (clk),
    .rst         (rst),
    .rx_data     (rx_data),
    .new_rx_data (new_rx_data),
    .status      (status),
    .reset_req   (reset_req)
  );

  // Timestamp digits
  bin2bcd i_bin2bcd (
    .clk (clk),
    .bin (timestamp),
    .bcd (ts_bcd)
  );

  // Line sequencing
  report_seq i_report_seq (
    .clk         (clk),
    .rst         (rst),
    .tmr         (tmr),
    .tx_busy     (tx_busy),
    .status      (status),
    .ts_bcd      (ts_bcd),
    .snap        (snap),
    .idx         (idx),
    .new_tx_data (new_tx_data)
  );

  // Character for the current position goes straight to the link
  status_line i_status_line (
    .snap (snap),
    .idx  (idx),
    .ch   (tx_data)
  );

endmodule

//--- hw/report_seq.sv
/*
  Report sequencer
  Captures a snapshot on trigger and streams one line
  under tx_busy back-pressure
*/

`timescale 1ns/10ps

module report_seq (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 tmr,
  input  logic                 tx_busy,
  input  dbg_pkg::dbg_status_t status,
  input  dbg_pkg::bcd_vec_t    ts_bcd,
  output dbg_pkg::dbg_snap_t   snap,
  output dbg_pkg::char_idx_t   idx,
  output logic                 new_tx_data
);

  typedef enum logic {
    ST_IDLE,
    ST_SEND
  } state_t;

  state_t state_q;

  // Trigger accepted only while idle
  logic start;
  // Current character is the carriage return
  logic last_char;
  // A character leaves this cycle
  logic emit;

  assign start     = (state_q == ST_IDLE) && tmr;
  assign last_char = (idx == dbg_pkg::char_idx_t'(dbg_pkg::LINE_LEN - 1));
  assign emit      = (state_q == ST_SEND) && !tx_busy;

  // Strobe follows the link's busy flag in the same cycle
  assign new_tx_data = emit;

  // FSM and character index
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      idx     <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (tmr) begin
            state_q <= ST_SEND;
            idx     <= '0;
          end
        end
        ST_SEND: begin
          // Index holds while the link is busy
          if (!tx_busy) begin
            idx <= idx + 1'b1;
            if (last_char) begin
              state_q <= ST_IDLE;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Snapshot of flags and timestamp digits
  always_ff @(posedge clk) begin
    if (start) begin
      snap.status <= status;
      snap.bcd    <= ts_bcd;
    end
  end

  // Link contract, no strobe while busy
  a_no_strobe_busy: assert property (
    @(posedge clk) disable iff (rst)
    !(new_tx_data && tx_busy)
  ) else $error("report_seq strobe raised while tx_busy is high");

  // A line ends only after its carriage return went out
  a_full_line: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == ST_SEND) ##1 (state_q == ST_IDLE)
      |-> $past(new_tx_data) && ($past(idx) == dbg_pkg::char_idx_t'(dbg_pkg::LINE_LEN - 1))
  ) else $error("report_seq left the send state before the last character");

endmodule

//--- hw/status_line.sv
/*
  Status line composer
  Character at a line position from a captured snapshot
  Flag letters and BCD to ASCII conversion
*/

`timescale 1ns/10ps

module status_line (
  input  dbg_pkg::dbg_snap_t snap,
  input  dbg_pkg::char_idx_t idx,
  output logic [7:0]         ch
);

  // Decimal digit to its ASCII code
  function automatic logic [7:0] digit_char(input logic [3:0] d);
    return dbg_pkg::CH_ZERO + {4'd0, d};
  endfunction

  // Flag letters
  logic [7:0] motor_ch;
  logic [7:0] log_ch;

  assign motor_ch = snap.status.motor_armed ? dbg_pkg::CH_ARMED : dbg_pkg::CH_DISARMED;
  assign log_ch   = snap.status.logging ? dbg_pkg::CH_LOGGING : dbg_pkg::CH_IDLE;

  // Line layout
  // " A R T: 543.2  \r" with digits counted from the lsb
  always_comb begin
    case (idx)
      4'd0:  ch = dbg_pkg::CH_SPACE;
      // Motor state
      4'd1:  ch = motor_ch;
      4'd2:  ch = dbg_pkg::CH_SPACE;
      // Logging state
      4'd3:  ch = log_ch;
      4'd4:  ch = dbg_pkg::CH_SPACE;
      // Timestamp label
      4'd5:  ch = dbg_pkg::CH_T;
      4'd6:  ch = dbg_pkg::CH_COLON;
      4'd7:  ch = dbg_pkg::CH_SPACE;
      // Integer part of the timestamp
      4'd8:  ch = digit_char(snap.bcd[5]);
      4'd9:  ch = digit_char(snap.bcd[4]);
      4'd10: ch = digit_char(snap.bcd[3]);
      4'd11: ch = dbg_pkg::CH_DOT;
      // One fractional digit, lower two dropped
      4'd12: ch = digit_char(snap.bcd[2]);
      4'd13: ch = dbg_pkg::CH_SPACE;
      4'd14: ch = dbg_pkg::CH_SPACE;
      // Line terminator
      4'd15: ch = dbg_pkg::CH_CR;
      default: ch = dbg_pkg::CH_SPACE;
    endcase
  end

endmodule

//--- hw/cmd_decoder.sv
/*
  Terminal command decoder
  Toggles motor-arm and logging flags, raises a reset request pulse
*/

`timescale 1ns/10ps

module cmd_decoder (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [7:0]           rx_data,
  input  logic                 new_rx_data,
  output dbg_pkg::dbg_status_t status,
  output logic                 reset_req
);

  // Command matches on the strobed byte
  logic hit_reset;
  logic hit_motor;
  logic hit_data;

  assign hit_reset = new_rx_data && (rx_data == dbg_pkg::CMD_RESET);
  assign hit_motor = new_rx_data && (rx_data == dbg_pkg::CMD_MOTOR);
  assign hit_data  = new_rx_data && (rx_data == dbg_pkg::CMD_DATA);

  // Flags and request pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      status    <= '0;
      reset_req <= 1'b0;
    end else begin
      // Request lasts one cycle per "r"
      reset_req <= hit_reset;

      // Arm or disarm motors
      if (hit_motor) begin
        status.motor_armed <= ~status.motor_armed;
      end

      // Start or stop logging
      if (hit_data) begin
        status.logging <= ~status.logging;
      end
    end
  end

endmodule

//--- hw/bin2bcd.sv
/*
  Binary to BCD converter for the timestamp
  Combinational shift-and-add-3, eight decimal digits
  Digit range check sampled on clk
*/

`timescale 1ns/10ps

module bin2bcd (
  input  logic                        clk,
  input  logic [dbg_pkg::TS_BITS-1:0] bin,
  output dbg_pkg::bcd_vec_t           bcd
);

  // Working register, one nibble per digit
  logic [4*dbg_pkg::BCD_DIGITS-1:0] acc;

  always_comb begin
    acc = '0;
    // One pass per input bit, msb first
    for (int i = dbg_pkg::TS_BITS - 1; i >= 0; i--) begin
      // Correct digits that would overflow past 9 after the shift
      for (int d = 0; d < dbg_pkg::BCD_DIGITS; d++) begin
        if (acc[4*d +: 4] > 4'd4) begin
          acc[4*d +: 4] = acc[4*d +: 4] + 4'd3;
        end
      end
      // Shift next binary bit into digit 0
      acc = {acc[4*dbg_pkg::BCD_DIGITS-2:0], bin[i]};
    end
  end

  // Same bit layout as bcd_vec_t
  assign bcd = acc;

  // Each digit is a valid decimal value
  for (genvar g = 0; g < dbg_pkg::BCD_DIGITS; g++) begin : g_digit_chk
    a_digit_range: assert property (@(posedge clk) bcd[g] <= 4'd9)
      else $error("bin2bcd digit %0d out of range: %0h", g, bcd[g]);
  end

endmodule

//--- hw/dbg_pkg.sv
/*
  Shared definitions for the debug terminal
  Character codes, command bytes, line geometry and widths
  Status, BCD vector and snapshot structs
*/

package dbg_pkg;

  // Line geometry
  localparam int LINE_LEN   = 16;
  localparam int TS_BITS    = 24;
  localparam int BCD_DIGITS = 8;

  // Command bytes from the terminal
  localparam logic [7:0] CMD_RESET = "r";
  localparam logic [7:0] CMD_MOTOR = "m";
  localparam logic [7:0] CMD_DATA  = "d";

  // Fixed characters of the status line
  localparam logic [7:0] CH_SPACE = " ";
  localparam logic [7:0] CH_CR    = 8'h0d;
  localparam logic [7:0] CH_ZERO  = "0";
  localparam logic [7:0] CH_DOT   = ".";
  localparam logic [7:0] CH_COLON = ":";
  localparam logic [7:0] CH_T     = "T";

  // Flag letters
  localparam logic [7:0] CH_ARMED    = "A";
  localparam logic [7:0] CH_DISARMED = "D";
  localparam logic [7:0] CH_LOGGING  = "R";
  localparam logic [7:0] CH_IDLE     = "I";

  // Position within one line
  typedef logic [3:0] char_idx_t;

  // Terminal-controlled flags
  typedef struct packed {
    logic motor_armed;
    logic logging;
  } dbg_status_t;

  // Digit 0 is the least significant
  typedef logic [BCD_DIGITS-1:0][3:0] bcd_vec_t;

  // State frozen at the report trigger
  typedef struct packed {
    dbg_status_t status;
    bcd_vec_t    bcd;
  } dbg_snap_t;

endpackage
